// File: Makefile
VERILATOR ?= verilator
TOP       ?= reflet_periph_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  := Some tests failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/reflet_periph_props.sv
// Concurrent checks on the peripheral block, bound to reflet_periph.
// Covers the four-phase irq/irq_ack rule, cause latching and clearing,
// and the GPIO and timer interrupt timing.
`default_nettype none
`timescale 1ns/1ns

module reflet_periph_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   irq,
    input logic                   irq_ack,
    input logic                   gpio_irq,
    input logic                   timer_irq,
    input reflet_pkg::irq_state_t state,
    input logic [7:0]             pending,
    input logic [7:0]             served
);

    int unsigned fail_count = 0; // Read by the testbench at the end

    reset_idle: assert property (@(posedge clk) !reset |=> state == reflet_pkg::IDLE && !irq)
        else begin fail_count++; $error("state not IDLE or irq high after reset"); end

    irq_drops_on_ack: assert property (@(posedge clk) disable iff (!reset)
        irq && irq_ack |=> !irq)
        else begin fail_count++; $error("irq still high one cycle after irq_ack"); end

    no_irq_while_ack: assert property (@(posedge clk) disable iff (!reset)
        !irq && irq_ack |=> !irq)
        else begin fail_count++; $error("irq rose while irq_ack was high"); end

    gpio_edge_to_irq: assert property (@(posedge clk) disable iff (!reset)
        gpio_irq && state == reflet_pkg::IDLE && pending == 8'h00 && !irq_ack |=> ##1 irq)
        else begin fail_count++; $error("gpio edge did not raise irq two cycles later"); end

    timer_cause_set: assert property (@(posedge clk) disable iff (!reset)
        timer_irq |=> pending[reflet_pkg::IRQ_SRC_TIMER] && !timer_irq)
        else begin fail_count++; $error("timer pulse not latched or longer than a cycle"); end

    served_cleared: assert property (@(posedge clk) disable iff (!reset)
        state == reflet_pkg::RELEASE && !irq_ack && !gpio_irq && !timer_irq
        |=> (pending & served) == 8'h00)
        else begin fail_count++; $error("served causes still pending after release"); end

    held_cause_reraises: assert property (@(posedge clk) disable iff (!reset)
        state == reflet_pkg::RELEASE && !irq_ack && (pending & ~served) != 8'h00 |=> ##1 irq)
        else begin fail_count++; $error("held cause did not raise irq again"); end

endmodule

bind reflet_periph reflet_periph_props i_reflet_periph_props (
    .clk       (clk),
    .reset     (reset),
    .irq       (irq),
    .irq_ack   (irq_ack),
    .gpio_irq  (gpio_irq),
    .timer_irq (timer_irq),
    .state     (i_irq_ctrl.state),
    .pending   (i_irq_ctrl.pending),
    .served    (i_irq_ctrl.served)
);

`default_nettype wire

// File: dv/reflet_periph_tb.sv
// Testbench for the peripheral block. Drives the system bus and gpi,
// models the processor side of the irq handshake, and reports the
// bound assertion failures plus its own read data mismatches.
`default_nettype none
`timescale 1ns/1ns

module reflet_periph_tb;

    localparam int MAX_CYCLES = 3000;

    logic        clk;
    logic        reset;
    logic        enable;
    logic [15:0] addr;
    logic        write_en;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic        irq;
    logic        irq_ack;

    int          read_errors = 0;
    int          cycles = 0;
    int          period;
    int          pin;
    logic [15:0] mask;
    logic [15:0] other;
    logic [15:0] reload_val;
    logic [7:0]  rdata;
    logic [7:0]  cnt1;
    logic [7:0]  cnt2;
    logic [7:0]  wdata;

    reflet_periph i_reflet_periph (
        .clk(clk), .reset(reset), .enable(enable), .addr(addr), .write_en(write_en),
        .data_in(data_in), .data_out(data_out), .gpi(gpi), .gpo(gpo),
        .irq(irq), .irq_ack(irq_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // Processor side: ack after 1 to 4 cycles, drop once irq is low
    initial begin
        int delay;
        irq_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (irq && !irq_ack) begin
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk);
                irq_ack <= 1'b1;
                do @(posedge clk); while (irq);
                irq_ack <= 1'b0;
            end
        end
    end

    function automatic logic [15:0] gpio_addr(input logic [2:0] off);
        return reflet_pkg::GPIO_BASE + {13'b0, off};
    endfunction

    function automatic logic [15:0] timer_addr(input logic [2:0] off);
        return reflet_pkg::TIMER_BASE + {13'b0, off};
    endfunction

    task automatic write_reg(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        enable   <= 1'b1;
        write_en <= 1'b1;
        addr     <= a;
        data_in  <= d;
        @(negedge clk);
    endtask

    task automatic read_reg(input logic [15:0] a, input logic en, output logic [7:0] d);
        @(posedge clk);
        enable   <= en;
        write_en <= 1'b0;
        addr     <= a;
        @(negedge clk);
        d = data_out;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        enable   <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic check_read(input logic [15:0] a, input logic en, input logic [7:0] exp,
                              input string what);
        logic [7:0] d;
        read_reg(a, en, d);
        if (d !== exp) begin
            read_errors++;
            $display("FAILED at %0t: %s read %h, expected %h", $time, what, d, exp);
        end
    endtask

    task automatic set_gpi(input logic [15:0] v);
        @(posedge clk);
        gpi <= v;
    endtask

    task automatic wait_quiet();
        do @(negedge clk);
        while (irq || irq_ack || i_reflet_periph.i_irq_ctrl.pending != 8'h00);
    endtask

    task automatic wait_irq(input logic level);
        do @(negedge clk); while (irq !== level);
    endtask

    task automatic expect_no_irq(input int n);
        repeat (n) begin
            @(negedge clk);
            if (irq) begin
                read_errors++;
                $display("FAILED at %0t: irq raised without a masked edge", $time);
            end
        end
    endtask

    initial begin
        void'($urandom(69));
        reset = 1'b0;
        enable = 1'b0;
        write_en = 1'b0;
        addr = '0;
        data_in = '0;
        gpi = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b1;

        // Outputs after reset, then GPO writes
        check_read(gpio_addr(reflet_pkg::GPO_LO), 1'b1, 8'h00, "GPO_LO after reset");
        if (gpo !== 16'h0000) begin
            read_errors++;
            $display("FAILED at %0t: gpo %h after reset, expected 0000", $time, gpo);
        end
        wdata = 8'($urandom);
        write_reg(gpio_addr(reflet_pkg::GPO_LO), wdata);
        check_read(gpio_addr(reflet_pkg::GPO_LO), 1'b1, wdata, "GPO_LO");
        if (gpo[7:0] !== wdata) begin
            read_errors++;
            $display("FAILED at %0t: gpo low byte %h, expected %h", $time, gpo[7:0], wdata);
        end
        wdata = 8'($urandom);
        write_reg(gpio_addr(reflet_pkg::GPO_HI), wdata);
        check_read(gpio_addr(reflet_pkg::GPO_HI), 1'b1, wdata, "GPO_HI");
        if (gpo[15:8] !== wdata) begin
            read_errors++;
            $display("FAILED at %0t: gpo high byte %h, expected %h", $time, gpo[15:8], wdata);
        end

        // Input readback, masks, decode misses
        other = 16'($urandom);
        set_gpi(other);
        check_read(gpio_addr(reflet_pkg::GPI_LO), 1'b1, other[7:0], "GPI_LO");
        check_read(gpio_addr(reflet_pkg::GPI_HI), 1'b1, other[15:8], "GPI_HI");
        for (int r = 4; r < 8; r++) begin
            wdata = 8'($urandom);
            write_reg(gpio_addr(3'(r)), wdata);
            check_read(gpio_addr(3'(r)), 1'b1, wdata, "mask register");
        end
        check_read(16'h1234, 1'b1, 8'h00, "unmapped address");
        check_read(reflet_pkg::GPIO_BASE - 16'd1, 1'b1, 8'h00, "below GPIO window");
        check_read(timer_addr(3'd5), 1'b1, 8'h00, "past timer window");
        check_read(gpio_addr(reflet_pkg::GPO_LO), 1'b0, 8'h00, "read with enable low");

        // Rising edge on one masked pin
        for (int r = 4; r < 8; r++) write_reg(gpio_addr(3'(r)), 8'h00);
        bus_idle();
        set_gpi(16'h0000);
        wait_quiet();
        pin   = $urandom_range(15, 0);
        mask  = 16'd1 << pin;
        other = {mask[14:0], mask[15]};
        write_reg(gpio_addr(reflet_pkg::RISE_LO), mask[7:0]);
        write_reg(gpio_addr(reflet_pkg::RISE_HI), mask[15:8]);
        bus_idle();
        set_gpi(mask);
        wait_irq(1'b1);
        check_read(reflet_pkg::IRQ_BASE, 1'b1, 8'h01, "GPIO cause");
        wait_quiet();
        set_gpi(other); // Pin falls, neighbour rises, neither masked
        expect_no_irq(10);

        // Timer period and live count
        reload_val = 16'($urandom_range(60, 40));
        write_reg(timer_addr(reflet_pkg::RELOAD_LO), reload_val[7:0]);
        write_reg(timer_addr(reflet_pkg::RELOAD_HI), 8'h00);
        write_reg(timer_addr(reflet_pkg::CTRL), 8'h01);
        bus_idle();
        do @(negedge clk); while (!i_reflet_periph.timer_irq);
        period = 0;
        do begin
            @(negedge clk);
            period++;
        end while (!i_reflet_periph.timer_irq);
        if (period != int'(reload_val) + 1) begin
            read_errors++;
            $display("FAILED at %0t: timer period %0d, expected %0d", $time, period,
                     int'(reload_val) + 1);
        end
        read_reg(timer_addr(reflet_pkg::COUNT_LO), 1'b1, cnt1);
        read_reg(timer_addr(reflet_pkg::COUNT_LO), 1'b1, cnt2);
        if (cnt1 > reload_val[7:0] || cnt2 >= cnt1) begin
            read_errors++;
            $display("FAILED at %0t: count reads %0d then %0d", $time, cnt1, cnt2);
        end
        check_read(timer_addr(reflet_pkg::COUNT_HI), 1'b1, 8'h00, "COUNT_HI");
        wait_irq(1'b1);
        read_reg(reflet_pkg::IRQ_BASE, 1'b1, rdata);
        if (!rdata[reflet_pkg::IRQ_SRC_TIMER]) begin
            read_errors++;
            $display("FAILED at %0t: cause %h lacks the timer bit", $time, rdata);
        end

        // GPIO edge during a timer exchange is held and re-raises irq
        wait_irq(1'b0);
        wait_irq(1'b1);
        set_gpi(other | mask);
        wait_irq(1'b0);
        wait_irq(1'b1);
        read_reg(reflet_pkg::IRQ_BASE, 1'b1, rdata);
        if (!rdata[reflet_pkg::IRQ_SRC_GPIO]) begin
            read_errors++;
            $display("FAILED at %0t: held GPIO cause missing, cause %h", $time, rdata);
        end
        write_reg(timer_addr(reflet_pkg::CTRL), 8'h00);
        bus_idle();
        wait_quiet();
        repeat (5) @(posedge clk);

        $display("Errors: %0d assertion failures, %0d read mismatches",
                 i_reflet_periph.i_reflet_periph_props.fail_count, read_errors);
        if (i_reflet_periph.i_reflet_periph_props.fail_count == 0 && read_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/reflet_pkg.sv
src/reflet_gpio.sv
src/reflet_timer.sv
src/reflet_irq_ctrl.sv
src/reflet_periph.sv
dv/reflet_periph_props.sv
dv/reflet_periph_tb.sv

// File: src/reflet_gpio.sv
// 16 general purpose outputs and 16 inputs on the system bus.
// Per-pin rising and falling edge masks drive a single interrupt line.
// All eight registers read back; reads are combinational.
`default_nettype none
`timescale 1ns/1ns

module reflet_gpio (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic [reflet_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                             write_en,
    input  logic [7:0]                       data_in,
    output logic [7:0]                       data_out,
    input  logic [15:0]                      gpi,
    output logic [15:0]                      gpo,
    output logic                             gpio_irq
);

    logic [reflet_pkg::ADDR_WIDTH-1:0] rel_addr;
    logic [2:0]  offset;
    logic        selected;
    logic [15:0] rise_mask;
    logic [15:0] fall_mask;
    logic [15:0] prev_gpi;
    logic [15:0] rising;
    logic [15:0] falling;

    assign rel_addr = addr - reflet_pkg::GPIO_BASE; // wraps high below the base
    assign offset   = rel_addr[2:0];
    assign selected = enable && (rel_addr < 16'd8);

    // Edge detection against last cycle's inputs
    assign rising   = gpi & ~prev_gpi;
    assign falling  = ~gpi & prev_gpi;
    assign gpio_irq = |(rising & rise_mask) || |(falling & fall_mask);

    always_ff @(posedge clk) begin
        if (!reset) begin
            gpo       <= '0;
            rise_mask <= '0;
            fall_mask <= '0;
            prev_gpi  <= '0;
        end else begin
            prev_gpi <= gpi;
            if (selected && write_en) begin
                case (offset)
                    reflet_pkg::GPO_LO:  gpo[7:0]        <= data_in;
                    reflet_pkg::GPO_HI:  gpo[15:8]       <= data_in;
                    reflet_pkg::RISE_LO: rise_mask[7:0]  <= data_in;
                    reflet_pkg::RISE_HI: rise_mask[15:8] <= data_in;
                    reflet_pkg::FALL_LO: fall_mask[7:0]  <= data_in;
                    reflet_pkg::FALL_HI: fall_mask[15:8] <= data_in;
                    default: ; // GPI is read only
                endcase
            end
        end
    end

    always_comb begin
        data_out = 8'h00;
        if (selected) begin
            case (offset)
                reflet_pkg::GPO_LO:  data_out = gpo[7:0];
                reflet_pkg::GPO_HI:  data_out = gpo[15:8];
                reflet_pkg::GPI_LO:  data_out = gpi[7:0];
                reflet_pkg::GPI_HI:  data_out = gpi[15:8];
                reflet_pkg::RISE_LO: data_out = rise_mask[7:0];
                reflet_pkg::RISE_HI: data_out = rise_mask[15:8];
                reflet_pkg::FALL_LO: data_out = fall_mask[7:0];
                reflet_pkg::FALL_HI: data_out = fall_mask[15:8];
                default:             data_out = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/reflet_irq_ctrl.sv
// Interrupt controller. Latches peripheral pulses into a cause byte and
// runs a four-phase irq/irq_ack exchange with the processor.
// The causes served by the current request read back at IRQ_BASE.
`default_nettype none
`timescale 1ns/1ns

module reflet_irq_ctrl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic [reflet_pkg::ADDR_WIDTH-1:0] addr,
    output logic [7:0]                       data_out,
    input  logic                             gpio_irq,
    input  logic                             timer_irq,
    output logic                             irq,
    input  logic                             irq_ack
);

    reflet_pkg::irq_state_t state;
    logic [7:0] pending;
    logic [7:0] served;
    logic [7:0] new_causes;
    logic [7:0] clear_mask;

    always_comb begin
        new_causes = 8'h00;
        new_causes[reflet_pkg::IRQ_SRC_GPIO]  = gpio_irq;
        new_causes[reflet_pkg::IRQ_SRC_TIMER] = timer_irq;
    end

    // Served causes drop as the processor releases ack
    assign clear_mask = (state == reflet_pkg::RELEASE && !irq_ack) ? served : 8'h00;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= reflet_pkg::IDLE;
            pending <= '0;
            served  <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | new_causes;
            case (state)
                reflet_pkg::IDLE: begin
                    if (pending != 8'h00 && !irq_ack) begin
                        state  <= reflet_pkg::REQUEST;
                        served <= pending; // Snapshot
                    end
                end
                reflet_pkg::REQUEST: begin
                    if (irq_ack) begin
                        state <= reflet_pkg::RELEASE;
                    end
                end
                reflet_pkg::RELEASE: begin
                    if (!irq_ack) begin
                        state <= reflet_pkg::IDLE;
                    end
                end
                default: state <= reflet_pkg::IDLE;
            endcase
        end
    end

    assign irq = (state == reflet_pkg::REQUEST);

    assign data_out = (enable && addr == reflet_pkg::IRQ_BASE) ? served : 8'h00;

endmodule

`default_nettype wire

// File: src/reflet_periph.sv
// Peripheral block of the 8-bit processor: GPIO, timer and interrupt
// controller on one system bus. Read data is the OR of all three,
// each peripheral drives zero outside its window.
`default_nettype none
`timescale 1ns/1ns

module reflet_periph (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic [reflet_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                             write_en,
    input  logic [7:0]                       data_in,
    output logic [7:0]                       data_out,
    input  logic [15:0]                      gpi,
    output logic [15:0]                      gpo,
    output logic                             irq,
    input  logic                             irq_ack
);

    logic [7:0] gpio_data;
    logic [7:0] timer_data;
    logic [7:0] irq_data;
    logic       gpio_irq;
    logic       timer_irq;

    reflet_gpio i_gpio (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (gpio_data),
        .gpi      (gpi),
        .gpo      (gpo),
        .gpio_irq (gpio_irq)
    );

    reflet_timer i_timer (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (timer_data),
        .timer_irq (timer_irq)
    );

    reflet_irq_ctrl i_irq_ctrl (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .addr      (addr),
        .data_out  (irq_data),
        .gpio_irq  (gpio_irq),
        .timer_irq (timer_irq),
        .irq       (irq),
        .irq_ack   (irq_ack)
    );

    assign data_out = gpio_data | timer_data | irq_data;

endmodule

`default_nettype wire

// File: src/reflet_pkg.sv
// Shared constants for the peripheral block on the 8-bit system bus.
// Bus windows, register offsets and the interrupt FSM states.
// Taken by scoped names, e.g. reflet_pkg::GPIO_BASE.
`default_nettype none

package reflet_pkg;

    localparam int ADDR_WIDTH = 16;

    // Register windows on the system bus
    localparam logic [ADDR_WIDTH-1:0] GPIO_BASE  = 16'hFF08; // 8 registers
    localparam logic [ADDR_WIDTH-1:0] TIMER_BASE = 16'hFF10; // 5 registers
    localparam logic [ADDR_WIDTH-1:0] IRQ_BASE   = 16'hFF18; // cause byte

    // GPIO offsets
    localparam logic [2:0] GPO_LO  = 3'd0;
    localparam logic [2:0] GPO_HI  = 3'd1;
    localparam logic [2:0] GPI_LO  = 3'd2;
    localparam logic [2:0] GPI_HI  = 3'd3;
    localparam logic [2:0] RISE_LO = 3'd4;
    localparam logic [2:0] RISE_HI = 3'd5;
    localparam logic [2:0] FALL_LO = 3'd6;
    localparam logic [2:0] FALL_HI = 3'd7;

    // Timer offsets
    localparam logic [2:0] RELOAD_LO = 3'd0;
    localparam logic [2:0] RELOAD_HI = 3'd1;
    localparam logic [2:0] CTRL      = 3'd2; // bit 0 is run
    localparam logic [2:0] COUNT_LO  = 3'd3;
    localparam logic [2:0] COUNT_HI  = 3'd4;

    // Bit positions in the cause byte
    localparam int IRQ_SRC_GPIO  = 0;
    localparam int IRQ_SRC_TIMER = 1;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE
    } irq_state_t;

endpackage

`default_nettype wire

// File: src/reflet_timer.sv
// 16-bit reload down-counter on the system bus.
// With run set it counts once per cycle; at zero it reloads and
// pulses timer_irq for one cycle, so the period is reload+1.
`default_nettype none
`timescale 1ns/1ns

module reflet_timer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic [reflet_pkg::ADDR_WIDTH-1:0] addr,
    input  logic                             write_en,
    input  logic [7:0]                       data_in,
    output logic [7:0]                       data_out,
    output logic                             timer_irq
);

    logic [reflet_pkg::ADDR_WIDTH-1:0] rel_addr;
    logic [2:0]  offset;
    logic        selected;
    logic [15:0] reload;
    logic [15:0] count;
    logic        run;

    assign rel_addr = addr - reflet_pkg::TIMER_BASE;
    assign offset   = rel_addr[2:0];
    assign selected = enable && (rel_addr < 16'd5);

    always_ff @(posedge clk) begin
        if (!reset) begin
            reload    <= '0;
            run       <= 1'b0;
            count     <= '0;
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= 1'b0;
            if (selected && write_en) begin
                case (offset)
                    reflet_pkg::RELOAD_LO: reload[7:0]  <= data_in;
                    reflet_pkg::RELOAD_HI: reload[15:8] <= data_in;
                    reflet_pkg::CTRL:      run          <= data_in[0];
                    default: ; // count is read only
                endcase
            end
            if (run) begin
                if (count == 16'd0) begin
                    count     <= reload;
                    timer_irq <= 1'b1; // Underflow
                end else begin
                    count <= count - 16'd1;
                end
            end
        end
    end

    always_comb begin
        data_out = 8'h00;
        if (selected) begin
            case (offset)
                reflet_pkg::RELOAD_LO: data_out = reload[7:0];
                reflet_pkg::RELOAD_HI: data_out = reload[15:8];
                reflet_pkg::CTRL:      data_out = {7'b0, run};
                reflet_pkg::COUNT_LO:  data_out = count[7:0]; // Live value
                reflet_pkg::COUNT_HI:  data_out = count[15:8];
                default:               data_out = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire
